/* logic/flush_control.sv */
// flush selector decode from cache flush strobes and registered sfence walk clear
`timescale 1ns/1ps
`default_nettype none

module flush_control (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               ic_flsh,   // instruction side flush strobe
    input  wire logic               dc_flsh,   // data side flush strobe
    input  wire logic               sfence,    // sfence.vma strobe
    output mmu_pkg::flush_sel_t     flush_sel,
    output logic                    walk_clear
);
    import mmu_pkg::*;

    always_comb begin
        case ({dc_flsh, ic_flsh})
            2'b01: begin
                flush_sel.mask  = id_region_mask;
                flush_sel.match = id_itlb_base;
            end
            2'b10: begin
                flush_sel.mask  = id_region_mask;
                flush_sel.match = id_dtlb_base;
            end
            2'b11: begin
                flush_sel.mask  = id_both_mask; // covers both regions
                flush_sel.match = id_itlb_base;
            end
            default: begin
                flush_sel.mask  = '0; // nothing flushed
                flush_sel.match = '0;
            end
        endcase
    end

    // whole walk state restarts one cycle after sfence
    always_ff @(posedge clk) begin
        walk_clear <= rst | sfence;
    end

endmodule

`default_nettype wire

/* logic/mmu_pkg.sv */
// shared request ids, satp modes, pte layout, walk and memory structs, flush match function
`default_nettype none

package mmu_pkg;

    typedef logic [7:0] id_t;   // zero means no request
    typedef logic [7:0] perm_t; // leaf pte low byte, zero on fault

    // id regions of the two miss channels
    localparam id_t id_itlb_base   = 8'b1000_0000; // instruction misses 100x_xxxx
    localparam id_t id_dtlb_base   = 8'b1100_0000; // data misses 110x_xxxx
    localparam id_t id_region_mask = 8'b0011_1111; // one flush strobe
    localparam id_t id_both_mask   = 8'b0111_1111; // both flush strobes

    localparam logic [3:0] satp_mode_sv39 = 4'd8;
    localparam logic [3:0] satp_mode_sv48 = 4'd9;
    localparam logic [3:0] satp_mode_sv57 = 4'd10;

    localparam int page_offset_bits = 12;
    localparam int vpn_bits         = 9;
    localparam int ppn_bits         = 44;
    localparam int max_levels       = 5;

    localparam int pte_bit_v = 0;
    localparam int pte_bit_r = 1;
    localparam int pte_bit_x = 3;

    typedef struct packed {
        id_t mask;  // id bits ignored by the compare
        id_t match; // id bits that must match
    } flush_sel_t;

    typedef struct packed {
        id_t         id;
        logic [63:0] vaddr;
        logic [63:0] satp;
    } walk_req_t;

    typedef struct packed {
        id_t         id;
        perm_t       perm;
        logic [63:0] paddr;
    } walk_resp_t;

    typedef struct packed {
        id_t         id;
        logic [63:0] addr;
    } mem_req_t;

    typedef struct packed {
        id_t         id;
        logic [7:0]  miss;  // nonzero means retry
        logic [63:0] rdata;
    } mem_resp_t;

    // true when a live id falls inside the flushed region
    function automatic logic is_flushed(input id_t id, input flush_sel_t sel);
        return (id != '0) && ((id & ~sel.mask) == (sel.match & ~sel.mask));
    endfunction

endpackage

`default_nettype wire

/* logic/mmu_walk_top.sv */
// walker top level joining flush decode, miss buffer and page table walker
`timescale 1ns/1ps
`default_nettype none

module mmu_walk_top (
    input  wire logic               clk,
    input  wire logic               rst,
    input  mmu_pkg::walk_req_t      it_req,
    input  mmu_pkg::walk_req_t      dt_req,
    input  wire logic               ic_flsh,
    input  wire logic               dc_flsh,
    input  wire logic               sfence,
    output mmu_pkg::mem_req_t       mem_req,
    input  mmu_pkg::mem_resp_t      mem_resp,
    output mmu_pkg::walk_resp_t     walk_resp
);
    import mmu_pkg::*;

    flush_sel_t flush_sel;  // shared cancel selector
    logic       walk_clear;
    walk_req_t  cur_req;    // buffered request shown to the walker

    flush_control u_flush_control (
        .clk        (clk),
        .rst        (rst),
        .ic_flsh    (ic_flsh),
        .dc_flsh    (dc_flsh),
        .sfence     (sfence),
        .flush_sel  (flush_sel),
        .walk_clear (walk_clear)
    );

    walk_request_buffer u_walk_request_buffer (
        .clk        (clk),
        .rst        (rst),
        .walk_clear (walk_clear),
        .flush_sel  (flush_sel),
        .it_req     (it_req),
        .dt_req     (dt_req),
        .resp_id    (walk_resp.id), // frees the answered entry
        .cur_req    (cur_req)
    );

    page_table_walker u_page_table_walker (
        .clk        (clk),
        .rst        (rst),
        .walk_clear (walk_clear),
        .flush_sel  (flush_sel),
        .cur_req    (cur_req),
        .mem_req    (mem_req),
        .mem_resp   (mem_resp),
        .walk_resp  (walk_resp)
    );

endmodule

`default_nettype wire

/* logic/page_table_walker.sv */
// Sv39/Sv48/Sv57 page table walk FSM with memory read port, superpage and fault handling
`timescale 1ns/1ps
`default_nettype none

module page_table_walker (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               walk_clear,
    input  mmu_pkg::flush_sel_t     flush_sel,
    input  mmu_pkg::walk_req_t      cur_req,
    output mmu_pkg::mem_req_t       mem_req,
    input  mmu_pkg::mem_resp_t      mem_resp,
    output mmu_pkg::walk_resp_t     walk_resp
);
    import mmu_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_addr,  // form pte address
        st_wait,  // read outstanding
        st_eval,  // decode pte
        st_done   // response pulse
    } walk_state_t;

    walk_state_t                              state;
    id_t                                      req_id;
    logic [max_levels-1:0][vpn_bits-1:0]      vpn;
    logic [ppn_bits-1:0]                      ppn;
    logic [$clog2(max_levels)-1:0]            level;  // current level, counts down to 0
    logic [63:0]                              pte;
    logic [63:0]                              pte_addr;
    perm_t                                    perm;

    logic                is_leaf;
    logic                misaligned;
    logic                fault;
    logic [ppn_bits-1:0] leaf_ppn;

    // pte decode for the evaluate state
    always_comb begin
        is_leaf    = pte[pte_bit_r] | pte[pte_bit_x];
        misaligned = 1'b0;
        leaf_ppn   = pte[10 +: ppn_bits];
        for (int i = 0; i < max_levels - 1; i++) begin
            if (i < level) begin
                if (pte[10 + i*vpn_bits +: vpn_bits] != '0) begin
                    misaligned = 1'b1; // superpage with low ppn bits set
                end
                leaf_ppn[i*vpn_bits +: vpn_bits] = vpn[i];
            end
        end
        fault = !pte[pte_bit_v] || (is_leaf && misaligned) ||
                (!is_leaf && (level == '0)); // no leaf at the last level
    end

    always_ff @(posedge clk) begin
        if (rst || walk_clear) begin
            state <= st_idle;
        end else if ((state != st_idle) && is_flushed(req_id, flush_sel)) begin
            state <= st_idle; // abandoned without response
        end else begin
            case (state)
                st_idle: begin
                    if ((cur_req.id != '0) && !is_flushed(cur_req.id, flush_sel)) begin
                        req_id <= cur_req.id;
                        vpn    <= cur_req.vaddr[page_offset_bits +: max_levels*vpn_bits];
                        ppn    <= cur_req.satp[ppn_bits-1:0];
                        state  <= st_addr;
                        case (cur_req.satp[63:60])
                            satp_mode_sv39: level <= 2;
                            satp_mode_sv48: level <= 3;
                            satp_mode_sv57: level <= 4;
                            default: begin
                                perm  <= '0; // unsupported mode faults at once
                                state <= st_done;
                            end
                        endcase
                    end
                end
                st_addr: begin
                    pte_addr <= 64'({ppn, vpn[level], 3'b000});
                    state    <= st_wait;
                end
                st_wait: begin
                    if ((mem_resp.id == req_id) && (mem_resp.miss == '0)) begin
                        pte   <= mem_resp.rdata;
                        state <= st_eval;
                    end
                end
                st_eval: begin
                    if (fault) begin
                        perm  <= '0;
                        state <= st_done;
                    end else if (is_leaf) begin
                        perm  <= pte[7:0];
                        ppn   <= leaf_ppn;
                        state <= st_done;
                    end else begin
                        ppn   <= pte[10 +: ppn_bits]; // next table
                        level <= level - 1'b1;
                        state <= st_addr;
                    end
                end
                default: begin
                    state <= st_idle; // done lasts one cycle
                end
            endcase
        end
    end

    always_comb begin
        mem_req.id   = (state == st_wait) ? req_id : '0;
        mem_req.addr = pte_addr;
    end

    always_comb begin
        walk_resp.id    = ((state == st_done) && !is_flushed(req_id, flush_sel)) ?
                          req_id : '0;
        walk_resp.perm  = perm;
        walk_resp.paddr = 64'({ppn, {page_offset_bits{1'b0}}});
    end

endmodule

`default_nettype wire

/* logic/walk_request_buffer.sv */
// two-entry translation miss buffer, data entry first, freed on response, flush or clear
`timescale 1ns/1ps
`default_nettype none

module walk_request_buffer (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               walk_clear,
    input  mmu_pkg::flush_sel_t     flush_sel,
    input  mmu_pkg::walk_req_t      it_req,
    input  mmu_pkg::walk_req_t      dt_req,
    input  mmu_pkg::id_t            resp_id,   // id answered by the walker this cycle
    output mmu_pkg::walk_req_t      cur_req
);
    import mmu_pkg::*;

    walk_req_t  req_in [2]; // slot 0 data, slot 1 instruction
    walk_req_t  ent [2];
    logic [1:0] take;       // capture into an empty slot
    logic [1:0] drop;       // release a held slot
    logic [1:0] ready;      // held and still live

    always_comb begin
        req_in[0] = dt_req;
        req_in[1] = it_req;
        for (int i = 0; i < 2; i++) begin
            drop[i] = (ent[i].id != '0) &&
                      ((ent[i].id == resp_id) || is_flushed(ent[i].id, flush_sel));
            // requester still shows an answered id on the response cycle
            take[i] = (ent[i].id == '0) && (req_in[i].id != '0) &&
                      (req_in[i].id != resp_id) &&
                      (req_in[i].id != ent[0].id) && (req_in[i].id != ent[1].id) &&
                      !is_flushed(req_in[i].id, flush_sel);
            ready[i] = (ent[i].id != '0) && !drop[i];
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            if (rst || walk_clear || drop[i]) begin
                ent[i].id <= '0;
            end else if (take[i]) begin
                ent[i] <= req_in[i];
            end
        end
    end

    // once presented, an entry stays on cur_req until answered or cancelled
    always_ff @(posedge clk) begin
        if (rst || walk_clear) begin
            cur_req.id <= '0;
        end else if (cur_req.id != '0) begin
            if ((cur_req.id == resp_id) || is_flushed(cur_req.id, flush_sel)) begin
                cur_req.id <= '0;
            end
        end else if (ready[0]) begin
            cur_req <= ent[0]; // data channel wins
        end else if (ready[1]) begin
            cur_req <= ent[1];
        end
    end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build and run the walker testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module mmu_walk_tb -f tb.f -o mmu_walk_sim

out=$(./obj_dir/mmu_walk_sim) || true
echo "$out"

if echo "$out" | grep -qx "All tests passed"; then
    exit 0
else
    exit 1
fi

/* sim/mmu_walk_props.sv */
// bound concurrent assertions on the page table walker ports
`timescale 1ns/1ps
`default_nettype none

module mmu_walk_props (
    input wire logic            clk,
    input wire logic            rst,
    input wire logic            walk_clear,
    input mmu_pkg::flush_sel_t  flush_sel,
    input mmu_pkg::mem_req_t    mem_req,
    input mmu_pkg::mem_resp_t   mem_resp,
    input mmu_pkg::walk_resp_t  walk_resp
);
    import mmu_pkg::*;

    // read id may only move once answered, flushed or cleared
    a_mem_req_stable: assert property (@(posedge clk) disable iff (rst)
        (mem_req.id != '0) && !walk_clear && !is_flushed(mem_req.id, flush_sel) &&
        !((mem_resp.id == mem_req.id) && (mem_resp.miss == '0))
        |=> (mem_req.id == $past(mem_req.id)))
        else $error("mem_req.id changed while waiting for memory");

    a_resp_pulse: assert property (@(posedge clk) disable iff (rst)
        (walk_resp.id != '0) |=> (walk_resp.id == '0))
        else $error("walk_resp.id held for more than one cycle");

    a_clear_quiet: assert property (@(posedge clk) disable iff (rst)
        walk_clear |=> (walk_resp.id == '0))
        else $error("walk_resp.id nonzero right after walk_clear");

endmodule

bind page_table_walker mmu_walk_props u_mmu_walk_props (
    .clk        (clk),
    .rst        (rst),
    .walk_clear (walk_clear),
    .flush_sel  (flush_sel),
    .mem_req    (mem_req),
    .mem_resp   (mem_resp),
    .walk_resp  (walk_resp)
);

`default_nettype wire

/* sim/mmu_walk_tb.sv */
// walker testbench with clock, reset, pte memory model, stimulus table, checks and watchdog
`timescale 1ns/1ps
`default_nettype none

module mmu_walk_tb;
    import mmu_pkg::*;

    typedef struct packed {
        logic [1:0]  chan;  // 0 instruction, 1 data, 2 both at once
        logic [1:0]  kind;  // 0 plain, 1 dc flush mid-walk, 2 sfence mid-walk
        logic [63:0] satp;
        logic [63:0] vaddr;
        perm_t       perm;
        logic [63:0] paddr;
    } row_t;

    logic        clk, rst, ic_flsh, dc_flsh, sfence;
    walk_req_t   it_req, dt_req;
    mem_req_t    mem_req;
    mem_resp_t   mem_resp;
    walk_resp_t  walk_resp;
    logic [63:0] pte_mem [logic [63:0]];
    row_t        rows [$];
    logic [43:0] next_table;
    int unsigned lcg_state;
    int          errors, checks, mem_wait;
    logic        mem_busy;
    id_t         mem_id;
    logic [63:0] mem_addr;

    mmu_walk_top u_mmu_walk_top (
        .clk(clk), .rst(rst), .it_req(it_req), .dt_req(dt_req),
        .ic_flsh(ic_flsh), .dc_flsh(dc_flsh), .sfence(sfence),
        .mem_req(mem_req), .mem_resp(mem_resp), .walk_resp(walk_resp)
    );

    always #20 clk = ~clk;

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [63:0] read_pte(input logic [63:0] addr);
        if (pte_mem.exists(addr)) return pte_mem[addr];
        return '0; // empty slot reads as invalid pte
    endfunction

    // memory answers 2 or 3 cycles after a read appears
    always @(posedge clk) begin
        mem_resp <= '0;
        if (rst) begin
            mem_busy <= 1'b0;
        end else if (mem_busy) begin
            if (mem_req.id != mem_id) begin
                mem_busy <= 1'b0; // walk abandoned
            end else if (mem_wait > 1) begin
                mem_wait <= mem_wait - 1;
            end else begin
                mem_resp <= {mem_id, 8'h00, read_pte(mem_addr)};
                mem_busy <= 1'b0;
            end
        end else if ((mem_req.id != '0) && (mem_resp.id == '0)) begin
            mem_busy <= 1'b1;
            mem_id   <= mem_req.id;
            mem_addr <= mem_req.addr;
            mem_wait <= 2 + int'((lcg_next() >> 16) & 1);
        end
    end

    // installs the pte chain and works out the expected answer
    task automatic add_row(input logic [1:0] chan, input logic [1:0] kind,
                           input logic [3:0] mode, input logic [63:0] vaddr,
                           input int leaf_level, input logic [43:0] leaf_ppn,
                           input logic [7:0] leaf_low);
        row_t        r;
        int          levels;
        logic [43:0] table_ppn, child, ppn_out;
        logic [63:0] vpn_f;
        logic        bad;
        levels = (mode == satp_mode_sv39) ? 3 : (mode == satp_mode_sv48) ? 4 :
                 (mode == satp_mode_sv57) ? 5 : 0;
        table_ppn = next_table;
        next_table = next_table + 1;
        r.chan = chan;
        r.kind = kind;
        r.vaddr = vaddr;
        r.satp = {mode, 16'h0, table_ppn};
        bad = (levels == 0) || !leaf_low[pte_bit_v];
        ppn_out = leaf_ppn;
        for (int lv = levels - 1; lv >= leaf_level; lv--) begin
            vpn_f = (vaddr >> (page_offset_bits + lv * vpn_bits)) & 64'h1ff;
            if (lv == leaf_level) begin
                pte_mem[{8'h0, table_ppn, 12'h0} + vpn_f * 8] = {10'h0, leaf_ppn, 10'h0} | leaf_low;
            end else begin
                child = next_table;
                next_table = next_table + 1;
                pte_mem[{8'h0, table_ppn, 12'h0} + vpn_f * 8] = {10'h0, child, 10'h0} | 64'h1;
                table_ppn = child;
            end
        end
        for (int lv = 0; lv < leaf_level; lv++) begin
            if (leaf_ppn[lv * vpn_bits +: vpn_bits] != '0) bad = 1'b1; // misaligned superpage
            ppn_out[lv * vpn_bits +: vpn_bits] =
                vaddr[page_offset_bits + lv * vpn_bits +: vpn_bits];
        end
        r.perm = bad ? 8'h00 : leaf_low;
        r.paddr = bad ? 64'h0 : {8'h0, ppn_out, 12'h0};
        rows.push_back(r);
    endtask

    task automatic build_table();
        add_row(0, 0, satp_mode_sv39, 64'h0000_0040_1234_5000, 0, 44'h0_0008_1234, 8'hcf);
        add_row(1, 0, satp_mode_sv39, 64'h0000_0000_8060_3000, 1, 44'h0_0009_0000, 8'hc7);
        add_row(0, 0, satp_mode_sv48, 64'h0000_7f12_3456_7000, 0, 44'h0_00a1_2345, 8'hcb);
        add_row(1, 0, satp_mode_sv57, 64'h00ab_cdef_1234_5000, 0, 44'h0_00b5_4321, 8'hc3);
        add_row(0, 0, 4'd0, 64'h0000_0000_1000_0000, 0, 44'h0_0000_0abc, 8'hcf); // bad mode
        add_row(1, 0, satp_mode_sv39, 64'h0000_0011_2233_4000, 0, 44'h0_0000_0def, 8'hce);
        add_row(0, 0, satp_mode_sv39, 64'h0000_0022_4466_8000, 1, 44'h0_0009_0005, 8'hcf);
        add_row(2, 0, satp_mode_sv39, 64'h0000_0033_5577_9000, 0, 44'h0_000c_0101, 8'hcb);
        add_row(1, 1, satp_mode_sv39, 64'h0000_0044_1111_2000, 0, 44'h0_000d_0202, 8'hcf);
        add_row(0, 0, satp_mode_sv48, 64'h0000_1234_5678_9000, 0, 44'h0_000e_0303, 8'hc9);
        add_row(0, 2, satp_mode_sv39, 64'h0000_0055_2222_3000, 0, 44'h0_000f_0404, 8'hcf);
        add_row(1, 0, satp_mode_sv39, 64'h0000_0066_3333_4000, 0, 44'h0_0010_0505, 8'hcb);
    endtask

    task automatic check_resp(input id_t exp_id, input row_t r);
        checks++;
        if (walk_resp.id != exp_id) begin
            $display("error at %0t: walk_resp.id got %h expected %h", $time, walk_resp.id, exp_id);
            errors++;
        end
        if (walk_resp.perm != r.perm) begin
            $display("error at %0t: walk_resp.perm got %h expected %h",
                     $time, walk_resp.perm, r.perm);
            errors++;
        end
        if ((r.perm != '0) && (walk_resp.paddr != r.paddr)) begin
            $display("error at %0t: walk_resp.paddr got %h expected %h",
                     $time, walk_resp.paddr, r.paddr);
            errors++;
        end
    endtask

    task automatic run_row(input int i);
        row_t r;
        id_t  iid, did, cid;
        id_t  expect_q [$];
        int   waited, row_err;
        r = rows[i];
        iid = id_itlb_base | id_t'(i);
        did = id_dtlb_base | id_t'(i);
        cid = (r.chan == 1) ? did : iid;
        row_err = errors;
        if (r.chan != 0) expect_q.push_back(did); // data answered first
        if (r.chan != 1) expect_q.push_back(iid);
        @(posedge clk);
        if (r.chan != 0) dt_req <= {did, r.vaddr, r.satp};
        if (r.chan != 1) it_req <= {iid, r.vaddr, r.satp};
        waited = 0;
        if (r.kind == 0) begin
            while ((expect_q.size() > 0) && (waited < 60)) begin
                @(posedge clk);
                waited++;
                if (walk_resp.id != '0) begin
                    check_resp(expect_q[0], r);
                    if (walk_resp.id == did) dt_req <= '0;
                    if (walk_resp.id == iid) it_req <= '0;
                    expect_q.delete(0);
                end
            end
            if (expect_q.size() > 0) begin
                $display("row %0d: no response for id %h", i, expect_q[0]);
                errors++;
            end
        end else begin
            while ((mem_req.id != cid) && (waited < 60)) begin
                @(posedge clk);
                waited++;
            end
            if (mem_req.id != cid) begin
                $display("row %0d: walk for id %h never reached memory", i, cid);
                errors++;
            end
            if (r.kind == 1) dc_flsh <= 1'b1;
            else sfence <= 1'b1;
            dt_req <= '0;
            it_req <= '0;
            @(posedge clk);
            dc_flsh <= 1'b0;
            sfence <= 1'b0;
            repeat (20) begin
                @(posedge clk);
                checks++;
                if (walk_resp.id == cid) begin
                    $display("row %0d: cancelled id %h still got a response", i, cid);
                    errors++;
                end
            end
        end
        it_req <= '0;
        dt_req <= '0;
        $display("row %0d %s", i, (errors == row_err) ? "ok" : "failed");
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        it_req = '0;
        dt_req = '0;
        ic_flsh = 1'b0;
        dc_flsh = 1'b0;
        sfence = 1'b0;
        mem_resp = '0;
        mem_busy = 1'b0;
        mem_wait = 0;
        mem_id = '0;
        mem_addr = '0;
        lcg_state = 23;
        next_table = 44'h100;
        errors = 0;
        checks = 0;
        build_table();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < rows.size(); i++) begin
            run_row(i);
            repeat (4) @(posedge clk);
        end
        $display("rows %0d checks %0d errors %0d", rows.size(), checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // whole run bounded by 60 cycles per row
    initial begin
        @(negedge rst);
        #(rows.size() * 60 * 40);
        $display("watchdog expired before all rows finished");
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
logic/mmu_pkg.sv
logic/flush_control.sv
logic/walk_request_buffer.sv
logic/page_table_walker.sv
logic/mmu_walk_top.sv
sim/mmu_walk_props.sv
sim/mmu_walk_tb.sv
